// File: hdl/IntExecPkg.sv
// Sizes and widths of the integer execution back end
// Op-type, condition, ALU and shift encodings
// Op word union with its integer and branch views
package IntExecPkg;

    // Data path, PC and register file sizes
    localparam int DataWidth     = 32;
    localparam int AddrWidth     = 16;
    localparam int RegCount      = 16;
    localparam int RegIdxWidth   = 4;
    localparam int QueueDepth    = 4;
    localparam int QueuePtrWidth = $clog2(QueueDepth);
    localparam int InsnBytes     = 4;
    localparam int ImmWidth      = 9;
    localparam int BrDispWidth   = 12;
    localparam int ShamtWidth    = 5;

    // Op types
    localparam logic [1:0] OpAlu    = 2'd0;
    localparam logic [1:0] OpShift  = 2'd1;
    localparam logic [1:0] OpBranch = 2'd2;
    localparam logic [1:0] OpSelect = 2'd3;

    // Conditions, code 7 is spare and behaves like CondAl
    localparam logic [2:0] CondEq  = 3'd0;
    localparam logic [2:0] CondNe  = 3'd1;
    localparam logic [2:0] CondLt  = 3'd2;
    localparam logic [2:0] CondGe  = 3'd3;
    localparam logic [2:0] CondLtu = 3'd4;
    localparam logic [2:0] CondGeu = 3'd5;
    localparam logic [2:0] CondAl  = 3'd6;

    // ALU functions
    localparam logic [2:0] AluAdd = 3'd0;
    localparam logic [2:0] AluSub = 3'd1;
    localparam logic [2:0] AluAnd = 3'd2;
    localparam logic [2:0] AluOr  = 3'd3;
    localparam logic [2:0] AluXor = 3'd4;
    localparam logic [2:0] AluSlt = 3'd5;

    // Shift kinds
    localparam logic [1:0] ShiftLl = 2'd0;
    localparam logic [1:0] ShiftRl = 2'd1;
    localparam logic [1:0] ShiftRa = 2'd2;

    // Integer view: ALU, shift and select ops
    typedef struct packed {
        logic [1:0]             opType;
        logic [2:0]             cond;
        logic [RegIdxWidth-1:0] dst;
        logic [RegIdxWidth-1:0] srcA;
        logic [RegIdxWidth-1:0] srcB;
        logic [2:0]             aluCode;
        logic [1:0]             shiftKind;
        logic                   useImm;
        logic [ImmWidth-1:0]    imm;
    } IntOpView;

    // Branch view, same 17-bit header
    typedef struct packed {
        logic [1:0]             opType;
        logic [2:0]             cond;
        logic [RegIdxWidth-1:0] dst;
        logic [RegIdxWidth-1:0] srcA;
        logic [RegIdxWidth-1:0] srcB;
        logic [BrDispWidth-1:0] disp;
        logic                   predTaken;
        logic [1:0]             spare;
    } BrOpView;

    typedef union packed {
        IntOpView intView;
        BrOpView  brView;
    } OpWord;

endpackage

// File: hdl/IntAlu.sv
// Combinational ALU and shifter
// Controlled by the integer view of the op word
`timescale 1ns/1ns

module IntAlu import IntExecPkg::*; (
    input  IntOpView             opView,
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    output logic [DataWidth-1:0] aluOut,
    output logic [DataWidth-1:0] shiftOut
);

    logic [DataWidth-1:0]  immExt;
    logic [DataWidth-1:0]  srcB;
    logic [ShamtWidth-1:0] shamt;

    // Sign-extended immediate replaces operand B
    assign immExt = {{(DataWidth-ImmWidth){opView.imm[ImmWidth-1]}}, opView.imm};
    assign srcB   = opView.useImm ? immExt : opB;
    assign shamt  = srcB[ShamtWidth-1:0];

    always_comb begin
        case (opView.aluCode)
            AluAdd: aluOut = opA + srcB;
            AluSub: aluOut = opA - srcB;
            AluAnd: aluOut = opA & srcB;
            AluOr:  aluOut = opA | srcB;
            AluXor: aluOut = opA ^ srcB;
            AluSlt: aluOut = {{(DataWidth-1){1'b0}}, $signed(opA) < $signed(srcB)};
            // unused codes fall back to add
            default: aluOut = opA + srcB;
        endcase
    end

    always_comb begin
        case (opView.shiftKind)
            ShiftLl: shiftOut = opA << shamt;
            ShiftRl: shiftOut = opA >> shamt;
            ShiftRa: shiftOut = $signed(opA) >>> shamt;
            // Spare kind shifts left
            default: shiftOut = opA << shamt;
        endcase
    end

endmodule

// File: hdl/IntRegRead.sv
// Register read stage
// 16-entry register file, pending-write scoreboard and op acceptance
`timescale 1ns/1ns

module IntRegRead import IntExecPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // Op input handshake
    input  logic                   opValid,
    output logic                   opReady,
    input  OpWord                  opWord,
    input  logic [AddrWidth-1:0]   opPc,

    // Push side of the op queue
    input  logic                   qFull,
    output logic                   qPush,
    output OpWord                  qWord,
    output logic [AddrWidth-1:0]   qPc,
    output logic [DataWidth-1:0]   qOpA,
    output logic [DataWidth-1:0]   qOpB,

    // Writeback from the execute unit
    input  logic                   wbEn,
    input  logic [RegIdxWidth-1:0] wbDst,
    input  logic [DataWidth-1:0]   wbData
);

    logic [DataWidth-1:0]   regFile [RegCount];
    logic [RegCount-1:0]    pending;
    logic                   running;
    logic                   regsBusy;
    logic                   accept;
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] srcB;
    logic [RegIdxWidth-1:0] dst;

    // Header fields sit at the same place in both views
    assign srcA = opWord.intView.srcA;
    assign srcB = opWord.intView.srcB;
    assign dst  = opWord.intView.dst;

    // r0 never gets a pending bit, so it never stalls
    assign regsBusy = pending[srcA] | pending[srcB] | pending[dst];

    assign opReady = running && !qFull && !regsBusy;
    assign accept  = opValid && opReady;

    // Goes high one cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // Register file and scoreboard
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            for (int i = 0; i < RegCount; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            // Writes to r0 are dropped here
            if (wbEn && wbDst != '0) begin
                regFile[wbDst] <= wbData;
                pending[wbDst] <= 1'b0;
            end
            // dst is free when accepted, so it never collides with the writeback
            if (accept && dst != '0) begin
                pending[dst] <= 1'b1;
            end
        end
    end

    // Push strobe one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            qPush <= 1'b0;
        end else begin
            qPush <= accept;
        end
    end

    // Op payload with the operands read in the accepting cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            qWord <= opWord;
            qPc   <= opPc;
            qOpA  <= regFile[srcA];
            qOpB  <= regFile[srcB];
        end
    end

endmodule

// File: hdl/IntOpQueue.sv
// Op queue between register read and execute
// Circular buffer of ops with operands and PC
`timescale 1ns/1ns

module IntOpQueue import IntExecPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 qPush,
    input  OpWord                pushWord,
    input  logic [AddrWidth-1:0] pushPc,
    input  logic [DataWidth-1:0] pushOpA,
    input  logic [DataWidth-1:0] pushOpB,
    output logic                 qFull,
    output logic                 qValid,
    input  logic                 qPop,
    output OpWord                headWord,
    output logic [AddrWidth-1:0] headPc,
    output logic [DataWidth-1:0] headOpA,
    output logic [DataWidth-1:0] headOpB
);

    OpWord                  wordMem [QueueDepth];
    logic [AddrWidth-1:0]   pcMem   [QueueDepth];
    logic [DataWidth-1:0]   opAMem  [QueueDepth];
    logic [DataWidth-1:0]   opBMem  [QueueDepth];
    logic [QueuePtrWidth-1:0] wrPtr;
    logic [QueuePtrWidth-1:0] rdPtr;
    logic [QueuePtrWidth:0]   count;
    logic                     doPop;

    assign qValid = count != '0;
    assign doPop  = qPop && qValid;

    // Full also counts the push of this cycle, since the register read
    // stage pushes one cycle after it accepts
    assign qFull = (count == (QueuePtrWidth+1)'(QueueDepth)) ||
                   (qPush && count == (QueuePtrWidth+1)'(QueueDepth - 1));

    assign headWord = wordMem[rdPtr];
    assign headPc   = pcMem[rdPtr];
    assign headOpA  = opAMem[rdPtr];
    assign headOpB  = opBMem[rdPtr];

    // Pointers wrap by overflow, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (qPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + qPush - doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (qPush) begin
            wordMem[wrPtr] <= pushWord;
            pcMem[wrPtr]   <= pushPc;
            opAMem[wrPtr]  <= pushOpA;
            opBMem[wrPtr]  <= pushOpB;
        end
    end

endmodule

// File: hdl/IntExecUnit.sv
// Execute stage
// Condition evaluation, result select, branch resolution
// Output register with valid/ready and register writeback
`timescale 1ns/1ns

module IntExecUnit import IntExecPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   qValid,
    output logic                   qPop,
    input  OpWord                  headWord,
    input  logic [AddrWidth-1:0]   headPc,
    input  logic [DataWidth-1:0]   headOpA,
    input  logic [DataWidth-1:0]   headOpB,
    output logic                   resValid,
    input  logic                   resReady,
    output logic [RegIdxWidth-1:0] resDst,
    output logic [DataWidth-1:0]   resData,
    output logic                   brValid,
    output logic                   brTaken,
    output logic [AddrWidth-1:0]   brTarget,
    output logic                   brMispred,
    output logic                   wbEn,
    output logic [RegIdxWidth-1:0] wbDst,
    output logic [DataWidth-1:0]   wbData
);

    logic [DataWidth-1:0] aluOut;
    logic [DataWidth-1:0] shiftOut;
    logic [DataWidth-1:0] resultNext;
    logic [AddrWidth-1:0] pcNext;
    logic [AddrWidth-1:0] dispExt;
    logic                 condTrue;
    logic                 isBranch;

    IntAlu alu (
        .opView   (headWord.intView),
        .opA      (headOpA),
        .opB      (headOpB),
        .aluOut   (aluOut),
        .shiftOut (shiftOut)
    );

    // Condition on the raw register operands
    always_comb begin
        case (headWord.intView.cond)
            CondEq:  condTrue = headOpA == headOpB;
            CondNe:  condTrue = headOpA != headOpB;
            CondLt:  condTrue = $signed(headOpA) < $signed(headOpB);
            CondGe:  condTrue = $signed(headOpA) >= $signed(headOpB);
            CondLtu: condTrue = headOpA < headOpB;
            CondGeu: condTrue = headOpA >= headOpB;
            CondAl:  condTrue = 1'b1;
            default: condTrue = 1'b1;
        endcase
    end

    assign isBranch = headWord.intView.opType == OpBranch;
    assign pcNext   = headPc + AddrWidth'(InsnBytes);
    assign dispExt  = {{(AddrWidth-BrDispWidth){headWord.brView.disp[BrDispWidth-1]}},
                       headWord.brView.disp};

    always_comb begin
        case (headWord.intView.opType)
            OpAlu:    resultNext = aluOut;
            OpShift:  resultNext = shiftOut;
            OpBranch: resultNext = {{(DataWidth-AddrWidth){1'b0}}, pcNext};
            default:  resultNext = condTrue ? headOpA : headOpB;
        endcase
    end

    // Load when the output register is empty or drains this cycle
    assign qPop = qValid && (!resValid || resReady);

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            brValid  <= 1'b0;
        end else if (qPop) begin
            resValid <= 1'b1;
            brValid  <= isBranch;
        end else if (resReady) begin
            resValid <= 1'b0;
            brValid  <= 1'b0;
        end
    end

    // Target wraps at 16 bits
    always_ff @(posedge clk) begin
        if (qPop) begin
            resDst    <= headWord.intView.dst;
            resData   <= resultNext;
            brTaken   <= isBranch && condTrue;
            brTarget  <= condTrue ? headPc + dispExt : pcNext;
            brMispred <= isBranch && (headWord.brView.predTaken != condTrue);
        end
    end

    // A result is committed when it is accepted
    assign wbEn   = resValid && resReady;
    assign wbDst  = resDst;
    assign wbData = resData;

endmodule

// File: hdl/IntExecCore.sv
// Integer execution back end top level
// Register read, op queue and execute unit
`timescale 1ns/1ns

module IntExecCore import IntExecPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   opValid,
    output logic                   opReady,
    input  OpWord                  opWord,
    input  logic [AddrWidth-1:0]   opPc,
    output logic                   resValid,
    input  logic                   resReady,
    output logic [RegIdxWidth-1:0] resDst,
    output logic [DataWidth-1:0]   resData,
    output logic                   brValid,
    output logic                   brTaken,
    output logic [AddrWidth-1:0]   brTarget,
    output logic                   brMispred
);

    // Register read to queue
    logic                   qPush;
    logic                   qFull;
    OpWord                  qWord;
    logic [AddrWidth-1:0]   qPc;
    logic [DataWidth-1:0]   qOpA;
    logic [DataWidth-1:0]   qOpB;

    // Queue head to execute
    logic                   qValid;
    logic                   qPop;
    OpWord                  headWord;
    logic [AddrWidth-1:0]   headPc;
    logic [DataWidth-1:0]   headOpA;
    logic [DataWidth-1:0]   headOpB;

    // Writeback
    logic                   wbEn;
    logic [RegIdxWidth-1:0] wbDst;
    logic [DataWidth-1:0]   wbData;

    IntRegRead regRead (
        .clk     (clk),
        .rst     (rst),
        .opValid (opValid),
        .opReady (opReady),
        .opWord  (opWord),
        .opPc    (opPc),
        .qFull   (qFull),
        .qPush   (qPush),
        .qWord   (qWord),
        .qPc     (qPc),
        .qOpA    (qOpA),
        .qOpB    (qOpB),
        .wbEn    (wbEn),
        .wbDst   (wbDst),
        .wbData  (wbData)
    );

    IntOpQueue opQueue (
        .clk      (clk),
        .rst      (rst),
        .qPush    (qPush),
        .pushWord (qWord),
        .pushPc   (qPc),
        .pushOpA  (qOpA),
        .pushOpB  (qOpB),
        .qFull    (qFull),
        .qValid   (qValid),
        .qPop     (qPop),
        .headWord (headWord),
        .headPc   (headPc),
        .headOpA  (headOpA),
        .headOpB  (headOpB)
    );

    IntExecUnit execUnit (
        .clk       (clk),
        .rst       (rst),
        .qValid    (qValid),
        .qPop      (qPop),
        .headWord  (headWord),
        .headPc    (headPc),
        .headOpA   (headOpA),
        .headOpB   (headOpB),
        .resValid  (resValid),
        .resReady  (resReady),
        .resDst    (resDst),
        .resData   (resData),
        .brValid   (brValid),
        .brTaken   (brTaken),
        .brTarget  (brTarget),
        .brMispred (brMispred),
        .wbEn      (wbEn),
        .wbDst     (wbDst),
        .wbData    (wbData)
    );

endmodule

// File: test/IntExecCore_chk.sv
// Protocol assertions for the integer execution back end
// Bound to the IntExecCore top level
`timescale 1ns/1ns

module IntExecCoreChk import IntExecPkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic                   opReady,
    input logic                   resValid,
    input logic                   resReady,
    input logic [RegIdxWidth-1:0] resDst,
    input logic [DataWidth-1:0]   resData,
    input logic                   brValid,
    input logic                   brTaken,
    input logic [AddrWidth-1:0]   brTarget,
    input logic                   brMispred
);

    // Number of failed assertions
    int failCount = 0;

    // Result held while the consumer stalls
    resultHeld: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable(resDst) && $stable(resData) &&
            $stable(brValid) && $stable(brTaken) && $stable(brTarget) && $stable(brMispred))
        else begin
            $error("result fields changed while resValid was high and resReady low");
            failCount++;
        end

    branchWithResult: assert property (@(posedge clk) disable iff (rst)
        brValid |-> resValid)
        else begin
            $error("brValid was high without resValid");
            failCount++;
        end

    // Both handshakes quiet right after reset
    quietAfterReset: assert property (@(posedge clk)
        rst |=> !opReady && !resValid)
        else begin
            $error("opReady or resValid high in the cycle after reset");
            failCount++;
        end

endmodule

bind IntExecCore IntExecCoreChk protocolChk (
    .clk       (clk),
    .rst       (rst),
    .opReady   (opReady),
    .resValid  (resValid),
    .resReady  (resReady),
    .resDst    (resDst),
    .resData   (resData),
    .brValid   (brValid),
    .brTaken   (brTaken),
    .brTarget  (brTarget),
    .brMispred (brMispred)
);

// File: test/IntExecCoreTb.sv
// Testbench for the integer execution back end
// LFSR-built op stream, in-order reference model and result comparison
// Random result back-pressure and a cycle-count timeout
`timescale 1ns/1ns

module IntExecCoreTb import IntExecPkg::*; ();

    localparam int                   NumOps        = 300;
    localparam int                   ClkPeriod     = 40;
    localparam int                   DriveDelay    = 5;
    localparam int                   ResetCycles   = 3;
    localparam int                   TimeoutCycles = NumOps * 20 + 200;
    localparam int                   DrainCycles   = 20;
    localparam int                   LongStall     = 8;
    localparam logic [31:0]          LfsrSeed      = 32'h1ae7be42;
    localparam logic [31:0]          LfsrTaps      = 32'h80200003;
    localparam logic [AddrWidth-1:0] PcStart       = 16'hff00;

    typedef struct packed {
        logic [RegIdxWidth-1:0] dst;
        logic [DataWidth-1:0]   data;
        logic                   isBranch;
        logic                   taken;
        logic [AddrWidth-1:0]   target;
        logic                   mispred;
    } ExpResult;

    logic                   clk;
    logic                   rst;
    logic                   opValid;
    logic                   opReady;
    OpWord                  opWord;
    logic [AddrWidth-1:0]   opPc;
    logic                   resValid;
    logic                   resReady;
    logic [RegIdxWidth-1:0] resDst;
    logic [DataWidth-1:0]   resData;
    logic                   brValid;
    logic                   brTaken;
    logic [AddrWidth-1:0]   brTarget;
    logic                   brMispred;

    logic [31:0]          lfsrState;
    OpWord                opList    [NumOps];
    logic [AddrWidth-1:0] pcList    [NumOps];
    logic [DataWidth-1:0] modelRegs [RegCount];
    logic                 readyPlan [TimeoutCycles];
    ExpResult             expQueue  [$];
    bit                   resetDone = 1'b0;
    int                   compared = 0;
    int                   mismatches = 0;
    int                   otherErrors = 0;
    int                   cycleCount = 0;
    int                   timedOut = 0;

    IntExecCore UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ LfsrTaps : lfsrState >> 1;
        end
        return bits;
    endfunction

    // Expected result of one op executed in program order
    function automatic ExpResult refExecute(input OpWord w, input logic [AddrWidth-1:0] pc,
                                            input logic [DataWidth-1:0] a,
                                            input logic [DataWidth-1:0] b);
        ExpResult             r;
        logic [DataWidth-1:0] opB;
        logic [AddrWidth-1:0] link;
        logic                 holds;
        r = '0;
        r.dst = w.intView.dst;
        opB = w.intView.useImm ? DataWidth'($signed(w.intView.imm)) : b;
        link = pc + AddrWidth'(InsnBytes);
        case (w.intView.cond)
            CondEq:  holds = a == b;
            CondNe:  holds = a != b;
            CondLt:  holds = $signed(a) < $signed(b);
            CondGe:  holds = !($signed(a) < $signed(b));
            CondLtu: holds = a < b;
            CondGeu: holds = !(a < b);
            default: holds = 1'b1;
        endcase
        case (w.intView.opType)
            OpAlu: begin
                case (w.intView.aluCode)
                    AluAdd:  r.data = a + opB;
                    AluSub:  r.data = a - opB;
                    AluAnd:  r.data = a & opB;
                    AluOr:   r.data = a | opB;
                    AluXor:  r.data = a ^ opB;
                    default: r.data = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
                endcase
            end
            OpShift: begin
                case (w.intView.shiftKind)
                    ShiftLl: r.data = a << opB[ShamtWidth-1:0];
                    ShiftRl: r.data = a >> opB[ShamtWidth-1:0];
                    default: r.data = $signed(a) >>> opB[ShamtWidth-1:0];
                endcase
            end
            OpBranch: begin
                r.isBranch = 1'b1;
                r.taken = holds;
                r.target = holds ? pc + AddrWidth'($signed(w.brView.disp)) : link;
                r.mispred = w.brView.predTaken != holds;
                r.data = {{(DataWidth - AddrWidth){1'b0}}, link};
            end
            default: r.data = holds ? a : b;
        endcase
        return r;
    endfunction

    // Random op on r0..r7
    // The first eight load each register from an immediate
    function automatic OpWord buildOp(input int idx, input logic [RegIdxWidth-1:0] lastDst);
        OpWord      w;
        logic [2:0] code;
        logic [1:0] kind;
        w = '0;
        if (idx < 8) begin
            w.intView.opType = OpAlu;
            w.intView.aluCode = AluAdd;
            w.intView.dst = RegIdxWidth'(idx);
            w.intView.useImm = 1'b1;
            w.intView.imm = 9'(takeBits(9));
            return w;
        end
        w.intView.opType = 2'(takeBits(2));
        w.intView.cond = 3'(takeBits(3));
        w.intView.dst = RegIdxWidth'(takeBits(3));
        w.intView.srcA = RegIdxWidth'(takeBits(3));
        w.intView.srcB = RegIdxWidth'(takeBits(3));
        // Chain on the previous result about half the time
        if (takeBits(1) != 0)
            w.intView.srcA = lastDst;
        if (w.intView.opType == OpBranch) begin
            w.brView.disp = 12'(takeBits(12));
            w.brView.predTaken = 1'(takeBits(1));
        end else begin
            code = 3'(takeBits(3));
            if (code > AluSlt)
                code = code - 3'd4;
            kind = 2'(takeBits(2));
            if (kind == 2'd3)
                kind = ShiftRa;
            w.intView.aluCode = code;
            w.intView.shiftKind = kind;
            w.intView.useImm = 1'(takeBits(1));
            w.intView.imm = 9'(takeBits(9));
        end
        return w;
    endfunction

    task automatic reportMismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] want);
        mismatches++;
        $display("MISMATCH at %0t: result %0d %s got %h expected %h",
                 $time, compared, field, got, want);
    endtask

    task automatic finishRun();
        if (UUT.protocolChk.failCount != 0) begin
            otherErrors += UUT.protocolChk.failCount;
            $display("ERROR: %0d protocol assertions failed", UUT.protocolChk.failCount);
        end
        if (compared != NumOps)
            $display("ERROR: %0d results compared but %0d ops were issued", compared, NumOps);
        $display("Summary: %0d results compared, %0d mismatches, %0d other errors, %0d timeouts",
                 compared, mismatches, otherErrors, timedOut);
        if (mismatches == 0 && otherErrors == 0 && timedOut == 0 && compared == NumOps) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Op list, expected results and ready pattern before the op issue
    initial begin
        logic [RegIdxWidth-1:0] lastDst;
        logic [AddrWidth-1:0]   pc;
        ExpResult               want;
        int                     lowLeft;
        rst = 1'b1;
        opValid = 1'b0;
        opWord = '0;
        opPc = '0;
        lfsrState = LfsrSeed;
        lastDst = '0;
        pc = PcStart;
        lowLeft = 0;
        for (int r = 0; r < RegCount; r++)
            modelRegs[r] = '0;
        for (int i = 0; i < NumOps; i++) begin
            opList[i] = buildOp(i, lastDst);
            pcList[i] = pc;
            want = refExecute(opList[i], pc, modelRegs[opList[i].intView.srcA],
                              modelRegs[opList[i].intView.srcB]);
            expQueue.push_back(want);
            // r0 stays zero
            if (want.dst != '0)
                modelRegs[want.dst] = want.data;
            lastDst = want.dst;
            pc = pc + AddrWidth'(InsnBytes);
        end
        for (int c = 0; c < TimeoutCycles; c++) begin
            if (lowLeft > 0) begin
                readyPlan[c] = 1'b0;
                lowLeft--;
            end else if (takeBits(4) == 0) begin
                readyPlan[c] = 1'b0;
                lowLeft = LongStall - 1;
            end else begin
                readyPlan[c] = takeBits(2) != 0;
            end
        end
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;
        resetDone = 1'b1;
        for (int i = 0; i < NumOps; i++) begin
            opValid = 1'b1;
            opWord = opList[i];
            opPc = pcList[i];
            @(posedge clk);
            while (!opReady)
                @(posedge clk);
            #DriveDelay;
        end
        opValid = 1'b0;
        wait (compared == NumOps);
        // Quiet window to catch extra results
        repeat (DrainCycles) @(posedge clk);
        finishRun();
    end

    // Result back-pressure
    initial begin
        resReady = 1'b0;
        wait (resetDone);
        for (int c = 0; c < TimeoutCycles; c++) begin
            @(posedge clk);
            #DriveDelay;
            resReady = readyPlan[c];
        end
    end

    // Compare every accepted result with the model
    always @(posedge clk) begin
        ExpResult want;
        if (!rst && resValid && resReady) begin
            if (expQueue.size() == 0) begin
                otherErrors++;
                $display("ERROR at %0t: result for r%0d arrived with no op outstanding",
                         $time, resDst);
            end else begin
                want = expQueue.pop_front();
                if (resDst !== want.dst)
                    reportMismatch("resDst", 32'(resDst), 32'(want.dst));
                if (resData !== want.data)
                    reportMismatch("resData", resData, want.data);
                if (brValid !== want.isBranch)
                    reportMismatch("brValid", 32'(brValid), 32'(want.isBranch));
                if (want.isBranch && brTaken !== want.taken)
                    reportMismatch("brTaken", 32'(brTaken), 32'(want.taken));
                if (want.isBranch && brTarget !== want.target)
                    reportMismatch("brTarget", 32'(brTarget), 32'(want.target));
                if (want.isBranch && brMispred !== want.mispred)
                    reportMismatch("brMispred", 32'(brMispred), 32'(want.mispred));
                compared++;
            end
        end
    end

    initial begin
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        timedOut = 1;
        $display("ERROR at %0t: timeout after %0d cycles with %0d of %0d results compared",
                 $time, cycleCount, compared, NumOps);
        finishRun();
    end

endmodule

// File: intExecCore.f
hdl/IntExecPkg.sv
hdl/IntAlu.sv
hdl/IntRegRead.sv
hdl/IntOpQueue.sv
hdl/IntExecUnit.sv
hdl/IntExecCore.sv
test/IntExecCore_chk.sv
test/IntExecCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the integer execution back end testbench with Verilator and runs it.
# The result is taken from the pass message in the simulation log.

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile="$buildDir/sim.log"

mkdir -p "$buildDir"
status=$?
if [ $status -ne 0 ]; then
    echo "Could not create $buildDir"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module IntExecCoreTb \
    -f intExecCore.f \
    -Mdir "$buildDir/obj" -o IntExecCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"$buildDir/obj/IntExecCoreSim" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$logFile"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $logFile"
exit 1
